// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_frame_counter
FILELIST  ?= frame_counter_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST OK" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== apu_bus_pkg.sv ====
package apu_bus_pkg;

	localparam int MODE_BIT    = 7; // 5-step select
	localparam int INHIBIT_BIT = 6;

	typedef struct packed {
		logic       wr_frame; // Mode register write
		logic       rd_status; // Status register read
		logic [7:0] data;
	} cpu_req_t;

	typedef struct packed {
		logic mode5;
		logic irq_inhibit;
	} frame_cfg_t;

endpackage

// ==== apu_timing_pkg.sv ====
package apu_timing_pkg;

	localparam int LFSR_W = 15;
	localparam int STEP_N = 5;

	typedef enum logic [2:0] {
		STEP1,
		STEP2,
		STEP3,
		STEP4_LAST, // 4-step mode only
		STEP5_LAST, // 5-step mode only
		ESCAPE // All-zero lockout, or no step
	} frame_step_e;

	// States after 3728, 7456, 11185, 14914 and 18640 shifts from all ones
	localparam logic [0:STEP_N-1][LFSR_W-1:0] STEP_STATE = {
		15'h1061,
		15'h3603,
		15'h2cd3,
		15'h0a1f,
		15'h7185
	};

	typedef struct packed {
		logic quarter; // Envelope and linear counter clock
		logic half; // Length counter and sweep clock
		logic irq_set;
	} frame_ticks_t;

endpackage

// ==== clk_divider.sv ====
`timescale 1ns/1ns

module clk_divider #(
	parameter int CLK_DIV = 12
) (
	input  logic clk,
	input  logic arst_n,
	output logic phi_en,
	output logic aclk_en,
	output logic m2
);

	localparam int CNT_W = $clog2(CLK_DIV);
	localparam int HALF  = CLK_DIV / 2;

	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_next;
	logic             wrap;
	logic             aclk_sel;

	assign wrap     = (cnt == CNT_W'(CLK_DIV - 1));
	assign cnt_next = wrap ? '0 : cnt + CNT_W'(1);

	// Outputs registered from the next count so they line up with cnt
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt      <= '0;
			phi_en   <= 1'b0;
			aclk_en  <= 1'b0;
			m2       <= 1'b0;
			aclk_sel <= 1'b0;
		end else begin
			cnt     <= cnt_next;
			phi_en  <= wrap; // High while cnt is 0
			aclk_en <= wrap & aclk_sel; // Every second phase
			m2      <= (cnt_next >= CNT_W'(HALF)); // Upper half of the phase
			if (wrap) begin
				aclk_sel <= ~aclk_sel;
			end
		end
	end

endmodule

// ==== frame_counter_top.f ====
apu_timing_pkg.sv
apu_bus_pkg.sv
clk_divider.sv
frame_regs.sv
frame_lfsr.sv
frame_decode.sv
frame_sequencer.sv
frame_counter_top.sv
tb_frame_counter.sv

// ==== frame_counter_top.sv ====
`timescale 1ns/1ns

module frame_counter_top #(
	parameter int CLK_DIV = 12
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  apu_bus_pkg::cpu_req_t req,
	input  logic                  dmc_irq,
	output logic                  m2,
	output logic                  quarter_tick,
	output logic                  half_tick,
	output logic                  irq,
	output logic                  status_irq
);

	import apu_bus_pkg::*;
	import apu_timing_pkg::*;

	logic         phi_en;
	logic         aclk_en;
	logic         cfg_wr;
	frame_cfg_t   cfg;
	frame_ticks_t ticks;

	clk_divider #(
		.CLK_DIV (CLK_DIV)
	) i_clk_divider (
		.clk     (clk),
		.arst_n  (arst_n),
		.phi_en  (phi_en),
		.aclk_en (aclk_en),
		.m2      (m2)
	);

	frame_regs i_frame_regs (
		.clk        (clk),
		.arst_n     (arst_n),
		.phi_en     (phi_en),
		.req        (req),
		.irq_set    (ticks.irq_set),
		.dmc_irq    (dmc_irq),
		.cfg        (cfg),
		.cfg_wr     (cfg_wr),
		.status_irq (status_irq),
		.irq        (irq)
	);

	frame_sequencer i_frame_sequencer (
		.clk     (clk),
		.arst_n  (arst_n),
		.aclk_en (aclk_en),
		.cfg     (cfg),
		.cfg_wr  (cfg_wr),
		.ticks   (ticks)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			quarter_tick <= 1'b0;
			half_tick    <= 1'b0;
		end else begin
			quarter_tick <= ticks.quarter;
			half_tick    <= ticks.half;
		end
	end

endmodule

// ==== frame_decode.sv ====
`timescale 1ns/1ns

module frame_decode (
	input  logic [apu_timing_pkg::LFSR_W-1:0] state,
	input  logic                              mode5,
	output apu_timing_pkg::frame_step_e       step,
	output logic                              step_hit
);

	import apu_timing_pkg::*;

	// Full-width compare per row, like the PLA terms
	always_comb begin
		step     = ESCAPE;
		step_hit = 1'b0;
		if (state == STEP_STATE[0]) begin
			step     = STEP1;
			step_hit = 1'b1;
		end else if (state == STEP_STATE[1]) begin
			step     = STEP2;
			step_hit = 1'b1;
		end else if (state == STEP_STATE[2]) begin
			step     = STEP3;
			step_hit = 1'b1;
		end else if (state == STEP_STATE[3] && !mode5) begin
			step     = STEP4_LAST;
			step_hit = 1'b1;
		end else if (state == STEP_STATE[STEP_N-1] && mode5) begin
			step     = STEP5_LAST;
			step_hit = 1'b1;
		end
	end

endmodule

// ==== frame_lfsr.sv ====
`timescale 1ns/1ns

module frame_lfsr (
	input  logic                              clk,
	input  logic                              arst_n,
	input  logic                              shift,
	input  logic                              reload,
	output logic [apu_timing_pkg::LFSR_W-1:0] state
);

	import apu_timing_pkg::*;

	logic feedback;

	// Taps 13 and 14, forced high to leave the all-zero state
	assign feedback = (state[LFSR_W-2] ^ state[LFSR_W-1]) | (state == '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= '1; // As if just reloaded
		end else if (reload) begin
			state <= '1;
		end else if (shift) begin
			state <= {state[LFSR_W-2:0], feedback};
		end
	end

endmodule

// ==== frame_regs.sv ====
`timescale 1ns/1ns

module frame_regs (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    phi_en,
	input  apu_bus_pkg::cpu_req_t   req,
	input  logic                    irq_set,
	input  logic                    dmc_irq,
	output apu_bus_pkg::frame_cfg_t cfg,
	output logic                    cfg_wr,
	output logic                    status_irq,
	output logic                    irq
);

	import apu_bus_pkg::*;

	logic wr_en;
	logic rd_en;
	logic inhibit_wr;
	logic frame_irq;

	// CPU strobes count only in a phase cycle
	assign wr_en      = phi_en & req.wr_frame;
	assign rd_en      = phi_en & req.rd_status;
	assign inhibit_wr = wr_en & req.data[INHIBIT_BIT];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg    <= '0;
			cfg_wr <= 1'b0;
		end else begin
			cfg_wr <= wr_en; // Lands with the new cfg
			if (wr_en) begin
				cfg.mode5       <= req.data[MODE_BIT];
				cfg.irq_inhibit <= req.data[INHIBIT_BIT];
			end
		end
	end

	// Clears win over a coincident set
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			frame_irq <= 1'b0;
		end else if (inhibit_wr || rd_en) begin
			frame_irq <= 1'b0;
		end else if (irq_set && !cfg.irq_inhibit) begin
			frame_irq <= 1'b1;
		end
	end

	assign status_irq = rd_en & frame_irq; // Old flag, cleared next cycle
	assign irq        = frame_irq | dmc_irq;

endmodule

// ==== frame_sequencer.sv ====
`timescale 1ns/1ns

module frame_sequencer (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         aclk_en,
	input  apu_bus_pkg::frame_cfg_t      cfg,
	input  logic                         cfg_wr,
	output apu_timing_pkg::frame_ticks_t ticks
);

	import apu_timing_pkg::*;

	logic [LFSR_W-1:0] state;
	frame_step_e       step;
	logic              step_hit;
	logic              last_hit;
	logic              half_step;
	logic              reload;
	logic              wr_pend;
	logic              last_q;
	logic              write_tick;

	frame_lfsr i_frame_lfsr (
		.clk    (clk),
		.arst_n (arst_n),
		.shift  (aclk_en),
		.reload (reload),
		.state  (state)
	);

	frame_decode i_frame_decode (
		.state    (state),
		.mode5    (cfg.mode5),
		.step     (step),
		.step_hit (step_hit)
	);

	assign last_hit  = step_hit & ((step == STEP4_LAST) | (step == STEP5_LAST));
	assign half_step = (step_hit & (step == STEP2)) | last_hit;

	// Ones are in place before the next aclk_en
	assign reload     = cfg_wr | last_q;
	assign write_tick = wr_pend & cfg.mode5;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_pend <= 1'b0;
			last_q  <= 1'b0;
		end else begin
			wr_pend <= cfg_wr | (wr_pend & ~aclk_en); // Held until next APU clock
			last_q  <= aclk_en & last_hit;
		end
	end

	always_comb begin
		ticks = '0;
		if (aclk_en) begin
			ticks.quarter = step_hit | write_tick;
			ticks.half    = half_step | write_tick;
			ticks.irq_set = step_hit & (step == STEP4_LAST);
		end
	end

endmodule

// ==== tb_frame_counter.sv ====
`timescale 1ns/1ns

module tb_frame_counter;

	import apu_bus_pkg::*;

	localparam int CLK_DIV    = 12;
	localparam int APU_CYCLES = 2 * CLK_DIV;
	localparam int TICK_LIMIT = 8000 * APU_CYCLES; // Longer than any step gap

	logic     clk;
	logic     arst_n;
	cpu_req_t req;
	logic     dmc_irq;
	logic     m2;
	logic     quarter_tick;
	logic     half_tick;
	logic     irq;
	logic     status_irq;

	int   rises; // m2 rises since reset, two per APU clock
	logic m2_q;
	logic phi_now; // Rebuilt phase strobe

	frame_counter_top #(
		.CLK_DIV (CLK_DIV)
	) i_frame_counter_top (
		.clk          (clk),
		.arst_n       (arst_n),
		.req          (req),
		.dmc_irq      (dmc_irq),
		.m2           (m2),
		.quarter_tick (quarter_tick),
		.half_tick    (half_tick),
		.irq          (irq),
		.status_irq   (status_irq)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Phase cycle is the first cycle with m2 low
	always @(negedge clk) begin
		if (!arst_n) begin
			rises   <= 0;
			m2_q    <= 1'b0;
			phi_now <= 1'b0;
		end else begin
			if (m2 && !m2_q)
				rises <= rises + 1;
			phi_now <= !m2 && m2_q;
			m2_q    <= m2;
		end
	end

	task automatic drive_point();
		@(posedge clk);
		#1;
	endtask

	task automatic next_sample();
		@(posedge clk);
		#3;
	endtask

	task automatic check_eq(input string what, input int got, input int exp);
		assert (got == exp) else begin
			$display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0t ns while waiting for %s", $time, what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic wait_quarter(input int limit, input bit irq_low, output int at,
			output bit half, output bit irq_at);
		bit found;
		found = 1'b0;
		for (int i = 0; i < limit && !found; i++) begin
			next_sample();
			if (quarter_tick) begin
				found  = 1'b1;
				at     = rises;
				half   = half_tick;
				irq_at = irq;
			end else begin
				check_eq("half_tick alone", half_tick, 0);
				if (irq_low)
					check_eq("irq between steps", irq, 0);
			end
		end
		if (!found)
			report_timeout("a quarter tick");
	endtask

	task automatic cpu_write(input logic [7:0] data);
		drive_point();
		req.wr_frame = 1'b1;
		req.data     = data;
		repeat (CLK_DIV) drive_point(); // Spans exactly one phase strobe
		req = '0;
	endtask

	task automatic read_status(output bit got);
		bit found;
		found = 1'b0;
		got   = 1'b0;
		drive_point();
		req.rd_status = 1'b1;
		for (int i = 0; i < CLK_DIV; i++) begin
			#2;
			if (phi_now) begin
				found = 1'b1;
				got   = status_irq;
			end
			drive_point();
		end
		req = '0;
		if (!found)
			report_timeout("a phase cycle during a status read");
	endtask

	task automatic test_divider();
		int high;
		int low;
		int n;
		bit m2_prev;
		n = 0;
		do begin
			m2_prev = m2;
			next_sample();
			n++;
		end while (!(m2 && !m2_prev) && n < 2 * CLK_DIV);
		if (n >= 2 * CLK_DIV)
			report_timeout("the first m2 rise");
		for (int p = 0; p < 50; p++) begin
			high = 1;
			low  = 0;
			while (m2 && high < 2 * CLK_DIV) begin
				next_sample();
				if (m2)
					high++;
			end
			while (!m2 && low < 2 * CLK_DIV) begin
				low++;
				next_sample();
			end
			check_eq("m2 high cycles", high, CLK_DIV / 2);
			check_eq("m2 low cycles", low, CLK_DIV / 2);
		end
	endtask

	// Starts right after a reset release
	task automatic test_four_step();
		int  gap4[4] = '{3729, 3728, 3729, 3729};
		int  at;
		int  prev;
		int  j;
		bit  half;
		bit  irq_at;
		wait_quarter(TICK_LIMIT, 1'b1, at, half, irq_at);
		check_eq("APU clocks to first step", at / 2, 3729);
		check_eq("half at step 1", half, 0);
		prev = at;
		for (int s = 2; s <= 9; s++) begin
			j = (s - 1) % 4;
			wait_quarter(TICK_LIMIT, s <= 4, at, half, irq_at);
			check_eq("4-step gap", (at - prev) / 2, gap4[j]);
			check_eq("4-step half tick", half, (j == 1 || j == 3));
			check_eq("irq at step", irq_at, s >= 4);
			prev = at;
		end
	endtask

	task automatic test_status_read();
		bit got;
		read_status(got);
		check_eq("status_irq with flag set", got, 1);
		next_sample();
		check_eq("irq after status read", irq, 0);
		read_status(got);
		check_eq("status_irq with flag clear", got, 0);
	endtask

	task automatic test_five_step();
		int gap5[4] = '{3728, 3728, 3729, 7455};
		int r0;
		int at;
		int prev;
		int j;
		bit half;
		bit irq_at;
		r0 = rises;
		cpu_write(8'h80);
		wait_quarter(4 * APU_CYCLES, 1'b1, at, half, irq_at);
		assert ((at - r0) <= 4) else begin
			$display("MISMATCH at %0t ns: write tick %0d m2 rises after write", $time, at - r0);
			$display("TEST FAILED");
			$fatal(1);
		end
		check_eq("half with write tick", half, 1);
		prev = at;
		for (int s = 1; s <= 8; s++) begin
			j = (s - 1) % 4;
			wait_quarter(TICK_LIMIT, 1'b1, at, half, irq_at);
			check_eq("5-step gap", (at - prev) / 2, (j == 0 && s > 1) ? 3729 : gap5[j]);
			check_eq("5-step half tick", half, (j == 1 || j == 3));
			check_eq("irq in 5-step mode", irq_at, 0);
			prev = at;
		end
	endtask

	task automatic test_inhibit();
		int at;
		bit half;
		bit irq_at;
		cpu_write(8'h00);
		for (int s = 1; s <= 4; s++)
			wait_quarter(TICK_LIMIT, s < 4, at, half, irq_at);
		check_eq("irq at step 4 after mode write", irq_at, 1);
		cpu_write(8'h40);
		next_sample();
		check_eq("irq after inhibit write", irq, 0);
		for (int s = 1; s <= 4; s++)
			wait_quarter(TICK_LIMIT, 1'b1, at, half, irq_at);
		check_eq("irq at inhibited step 4", irq_at, 0);
	endtask

	task automatic test_low_bits();
		int r0;
		int at;
		bit half;
		bit irq_at;
		for (int k = 0; k < 3; k++) begin
			r0 = rises;
			cpu_write(8'($urandom % 64));
			for (int i = 0; i < 3 * APU_CYCLES; i++) begin
				next_sample();
				check_eq("quarter_tick after low-bit write", quarter_tick, 0);
				check_eq("irq after low-bit write", irq, 0);
			end
		end
		wait_quarter(TICK_LIMIT, 1'b1, at, half, irq_at);
		assert ((at - r0) / 2 >= 3728 && (at - r0) / 2 <= 3731) else begin
			$display("MISMATCH at %0t ns: first step %0d APU clocks after write",
				$time, (at - r0) / 2);
			$display("TEST FAILED");
			$fatal(1);
		end
		check_eq("half at step 1", half, 0);
	endtask

	task automatic test_dmc();
		bit got;
		drive_point();
		dmc_irq = 1'b1;
		#2;
		check_eq("irq with dmc_irq", irq, 1);
		read_status(got);
		check_eq("status_irq with dmc_irq", got, 0);
		drive_point();
		dmc_irq = 1'b0;
		#2;
		check_eq("irq after dmc_irq release", irq, 0);
	endtask

	task automatic test_reset_mid_frame();
		int at;
		int n;
		bit half;
		bit irq_at;
		n = 0;
		do begin
			wait_quarter(TICK_LIMIT, 1'b0, at, half, irq_at);
			n++;
		end while (!irq_at && n < 4);
		check_eq("irq before reset", irq_at, 1);
		repeat (100 + $urandom % 50000) drive_point();
		arst_n = 1'b0;
		#2;
		check_eq("m2 in reset", m2, 0);
		check_eq("quarter_tick in reset", quarter_tick, 0);
		check_eq("half_tick in reset", half_tick, 0);
		check_eq("irq in reset", irq, 0);
		check_eq("status_irq in reset", status_irq, 0);
		repeat (16) drive_point();
		arst_n = 1'b1;
		test_four_step();
	endtask

	initial begin
		void'($urandom(65936));
		arst_n  = 1'b0;
		req     = '0;
		dmc_irq = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		arst_n = 1'b1;
		test_four_step();
		test_status_read();
		test_five_step();
		test_inhibit();
		test_low_bits();
		test_dmc();
		test_divider();
		test_reset_mid_frame();
		$display("TEST OK");
		$finish;
	end

endmodule
